//--- alpha_settings.svh
`ifndef ALPHA_SETTINGS_SVH
`define ALPHA_SETTINGS_SVH

// Qubit count, one Pauli literal per qubit in each row
`define ALPHA_NUM_QUBIT 4

// Rows held in P and in Q
`define ALPHA_MAX_VECTOR 16

`define ALPHA_AMP_W 2 // One real or imaginary component

`define ALPHA_WORD_W 8 // List-1 r, list-1 i, list-2 r, list-2 i

`endif

//--- alpha_pkg.sv
`default_nettype none

`include "alpha_settings.svh"

package alpha_pkg;

	// High bit is the X part, low bit the Z part
	typedef enum logic [1:0] {
		PAULI_I = 2'b00,
		PAULI_Z = 2'b01,
		PAULI_X = 2'b10,
		PAULI_Y = 2'b11
	} pauli_t;

	typedef pauli_t [0:`ALPHA_NUM_QUBIT-1] pauli_row_t; // Literal 0 leftmost
	typedef pauli_row_t [0:`ALPHA_MAX_VECTOR-1] row_list_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ALIGN,
		ST_WAIT_FLAG,
		ST_AMPLITUDE,
		ST_RESTORE
	} ctrl_state_t;

	typedef enum logic [2:0] {
		OP_HOLD,
		OP_LOAD_P,
		OP_ROT_P,
		OP_LOAD_Q,
		OP_ROT_PQ
	} store_op_t;

endpackage

`default_nettype wire

//--- pauli_row_mult.sv
`default_nettype none

`include "alpha_settings.svh"

module pauli_row_mult (
	input  alpha_pkg::pauli_row_t row_a,
	input  logic                  phase_a,
	input  alpha_pkg::pauli_row_t row_b,
	input  logic                  phase_b,
	output alpha_pkg::pauli_row_t row_out,
	output logic                  phase_out
);
	import alpha_pkg::*;

	logic [1:0] pow_i; // Accumulated power of i, mod 4

	always_comb
	begin
		pow_i = {phase_a ^ phase_b, 1'b0}; // Each sign bit counts as i^2
		for (int j = 0; j < `ALPHA_NUM_QUBIT; j++)
		begin
			row_out[j] = pauli_t'(row_a[j] ^ row_b[j]);
			case ({row_a[j], row_b[j]})
				{PAULI_X, PAULI_Y},
				{PAULI_Y, PAULI_Z},
				{PAULI_Z, PAULI_X}:
				begin
					pow_i = pow_i + 2'd1; // Cyclic order gives +i
				end
				{PAULI_Y, PAULI_X},
				{PAULI_Z, PAULI_Y},
				{PAULI_X, PAULI_Z}:
				begin
					pow_i = pow_i - 2'd1; // Anti-cyclic gives -i
				end
				default:
				begin
					pow_i = pow_i; // Identity or equal literals commute
				end
			endcase
		end
		phase_out = pow_i[1]; // Odd powers do not occur for commuting rows
	end

endmodule

`default_nettype wire

//--- pauli_row_store.sv
`default_nettype none

`include "alpha_settings.svh"

module pauli_row_store (
	input  logic                               clk,
	input  logic                               rst,
	input  alpha_pkg::store_op_t               store_op,
	input  alpha_pkg::row_list_t               p_rows,
	input  alpha_pkg::pauli_row_t              anticommute_row,
	input  logic [`ALPHA_MAX_VECTOR-1:0]       anticommute_phase,
	output alpha_pkg::row_list_t               q_rows,
	output logic [`ALPHA_MAX_VECTOR-1:0]       q_phase,
	output logic [`ALPHA_MAX_VECTOR-1:0]       p_lead_x
);
	import alpha_pkg::*;

	row_list_t                    p_reg;
	pauli_row_t                   prod_rows [`ALPHA_MAX_VECTOR];
	wire [`ALPHA_MAX_VECTOR-1:0]  prod_phase;

	// Literal j+1 moves to j, literal 0 wraps to the end
	function automatic pauli_row_t rot_left(input pauli_row_t row);
		pauli_row_t r;
		for (int j = 0; j < `ALPHA_NUM_QUBIT - 1; j++)
		begin
			r[j] = row[j+1];
		end
		r[`ALPHA_NUM_QUBIT-1] = row[0];
		return r;
	endfunction

	genvar g;
	generate
		for (g = 0; g < `ALPHA_MAX_VECTOR; g++)
		begin : gen_prod
			pauli_row_mult u_mult (
				.row_a     (p_reg[g]),
				.phase_a   (1'b0), // P rows carry no sign
				.row_b     (anticommute_row),
				.phase_b   (anticommute_phase[g]),
				.row_out   (prod_rows[g]),
				.phase_out (prod_phase[g])
			);
			assign p_lead_x[g] = p_reg[g][0][1]; // X bit at the cofactor qubit
		end
	endgenerate

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			p_reg   <= row_list_t'(0);
			q_rows  <= row_list_t'(0);
			q_phase <= '0;
		end
		else
		begin
			case (store_op)
				OP_LOAD_P:
				begin
					p_reg <= p_rows;
				end
				OP_ROT_P:
				begin
					for (int i = 0; i < `ALPHA_MAX_VECTOR; i++)
					begin
						p_reg[i] <= rot_left(p_reg[i]);
					end
				end
				OP_LOAD_Q:
				begin
					for (int i = 0; i < `ALPHA_MAX_VECTOR; i++)
					begin
						q_rows[i] <= prod_rows[i];
					end
					q_phase <= prod_phase;
				end
				OP_ROT_PQ:
				begin
					for (int i = 0; i < `ALPHA_MAX_VECTOR; i++)
					begin
						p_reg[i]  <= rot_left(p_reg[i]);
						q_rows[i] <= rot_left(q_rows[i]); // Sign is unaffected
					end
				end
				default:
				begin
					p_reg <= p_reg; // OP_HOLD
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- alpha_order.sv
`default_nettype none

`include "alpha_settings.svh"

module alpha_order (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          list_load,
	input  logic [`ALPHA_MAX_VECTOR-1:0]  p_lead_x,
	input  logic [`ALPHA_MAX_VECTOR-1:0]  anticommute_phase,
	input  logic                          amp_rotate,
	input  logic [`ALPHA_AMP_W-1:0]       amp_r,
	input  logic [`ALPHA_AMP_W-1:0]       amp_i,
	output logic [`ALPHA_WORD_W-1:0]      alpha_word
);

	localparam logic [`ALPHA_AMP_W-1:0] AMP_ONE  = `ALPHA_AMP_W'(1);
	localparam logic [`ALPHA_AMP_W-1:0] AMP_ZERO = '0;

	// Bit i belongs to row i; 0 puts P in list 1, 1 puts Q in list 1
	logic [`ALPHA_MAX_VECTOR-1:0] pq_list;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pq_list <= '0;
		end
		else if (list_load)
		begin
			// P at X with + sign, or at I with - sign, sends Q to list 1
			pq_list <= p_lead_x ^ anticommute_phase;
		end
		else if (amp_rotate)
		begin
			pq_list <= {pq_list[0], pq_list[`ALPHA_MAX_VECTOR-1:1]}; // Row 0 wraps to last
		end
	end

	always_comb
	begin
		if (pq_list[0] == 1'b0)
		begin
			alpha_word = {AMP_ONE, AMP_ZERO, amp_r, amp_i}; // P is list 1
		end
		else
		begin
			alpha_word = {amp_r, amp_i, AMP_ONE, AMP_ZERO}; // Q is list 1
		end
	end

endmodule

`default_nettype wire

//--- alpha_ram.sv
`default_nettype none

`include "alpha_settings.svh"

module alpha_ram (
	input  logic                                  clk,
	input  logic                                  amp_write,
	input  logic [$clog2(`ALPHA_MAX_VECTOR)-1:0]  amp_address,
	input  logic [`ALPHA_WORD_W-1:0]              alpha_word,
	input  logic [$clog2(`ALPHA_MAX_VECTOR)-1:0]  read_address,
	output logic [`ALPHA_AMP_W-1:0]               alpha1_r,
	output logic [`ALPHA_AMP_W-1:0]               alpha1_i,
	output logic [`ALPHA_AMP_W-1:0]               alpha2_r,
	output logic [`ALPHA_AMP_W-1:0]               alpha2_i
);

	logic [`ALPHA_WORD_W-1:0] mem [`ALPHA_MAX_VECTOR];
	logic [`ALPHA_WORD_W-1:0] rd_word;

	always_ff @(posedge clk)
	begin
		if (amp_write)
		begin
			mem[amp_address] <= alpha_word;
		end
		rd_word <= mem[read_address]; // Same-address write shows next cycle
	end

	assign {alpha1_r, alpha1_i, alpha2_r, alpha2_i} = rd_word;

endmodule

`default_nettype wire

//--- alpha_ctrl.sv
`default_nettype none

`include "alpha_settings.svh"

module alpha_ctrl (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 cfg_we,
	input  logic [$clog2(`ALPHA_NUM_QUBIT)-1:0]  cfg_cofactor_pos,
	input  logic                                 valid_p,
	input  logic                                 valid_anticommute,
	input  logic                                 flag_anticommute,
	input  logic                                 done_amplitude,
	output alpha_pkg::store_op_t                 store_op,
	output logic                                 list_load,
	output logic                                 determine_amplitude,
	output logic                                 idle
);
	import alpha_pkg::*;

	localparam int CNT_W = $clog2(`ALPHA_NUM_QUBIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`ALPHA_NUM_QUBIT - 1);

	ctrl_state_t      state;
	logic [CNT_W-1:0] step_cnt;
	logic [CNT_W-1:0] cofactor_pos;

	// Randomized outcome taken in the wait state
	assign list_load = (state == ST_WAIT_FLAG) && valid_anticommute && flag_anticommute;
	assign idle      = (state == ST_IDLE);

	always_comb
	begin
		case (state)
			ST_IDLE:      store_op = valid_p ? OP_LOAD_P : OP_HOLD;
			ST_ALIGN:     store_op = (step_cnt != cofactor_pos) ? OP_ROT_P : OP_HOLD;
			ST_WAIT_FLAG: store_op = list_load ? OP_LOAD_Q : OP_HOLD;
			ST_RESTORE:   store_op = OP_ROT_PQ; // Back toward the original qubit order
			default:      store_op = OP_HOLD;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state               <= ST_IDLE;
			step_cnt            <= '0;
			cofactor_pos        <= '0;
			determine_amplitude <= 1'b0;
		end
		else
		begin
			determine_amplitude <= list_load; // One-cycle request
			case (state)
				ST_IDLE:
				begin
					step_cnt <= '0;
					if (cfg_we)
					begin
						cofactor_pos <= cfg_cofactor_pos;
					end
					if (valid_p)
					begin
						state <= ST_ALIGN;
					end
				end
				ST_ALIGN:
				begin
					if (step_cnt == cofactor_pos)
					begin
						state <= ST_WAIT_FLAG; // Cofactor qubit now at literal 0
					end
					else
					begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				ST_WAIT_FLAG:
				begin
					if (valid_anticommute)
					begin
						if (flag_anticommute)
						begin
							state <= ST_AMPLITUDE;
						end
						else
						begin
							state    <= ST_IDLE; // Deterministic outcome
							step_cnt <= '0;
						end
					end
				end
				ST_AMPLITUDE:
				begin
					if (done_amplitude)
					begin
						if (cofactor_pos == '0)
						begin
							state    <= ST_IDLE;
							step_cnt <= '0;
						end
						else
						begin
							state <= ST_RESTORE; // Counter still holds pos
						end
					end
				end
				ST_RESTORE:
				begin
					if (step_cnt == CNT_LAST)
					begin
						state    <= ST_IDLE;
						step_cnt <= '0;
					end
					else
					begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				default:
				begin
					state    <= ST_IDLE;
					step_cnt <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- alpha_basis_top.sv
`default_nettype none

`include "alpha_settings.svh"

module alpha_basis_top (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  cfg_we,
	input  logic [$clog2(`ALPHA_NUM_QUBIT)-1:0]   cfg_cofactor_pos,
	input  logic                                  valid_p,
	input  alpha_pkg::row_list_t                  p_rows,
	input  logic                                  valid_anticommute,
	input  logic                                  flag_anticommute,
	input  alpha_pkg::pauli_row_t                 anticommute_row,
	input  logic [`ALPHA_MAX_VECTOR-1:0]          anticommute_phase,
	input  logic                                  done_amplitude,
	input  logic                                  amp_rotate,
	input  logic                                  amp_write,
	input  logic [$clog2(`ALPHA_MAX_VECTOR)-1:0]  amp_address,
	input  logic [`ALPHA_AMP_W-1:0]               amp_r,
	input  logic [`ALPHA_AMP_W-1:0]               amp_i,
	input  logic [$clog2(`ALPHA_MAX_VECTOR)-1:0]  read_address,
	output logic                                  determine_amplitude,
	output logic                                  idle,
	output alpha_pkg::row_list_t                  q_rows,
	output logic [`ALPHA_MAX_VECTOR-1:0]          q_phase,
	output logic [`ALPHA_AMP_W-1:0]               alpha1_r,
	output logic [`ALPHA_AMP_W-1:0]               alpha1_i,
	output logic [`ALPHA_AMP_W-1:0]               alpha2_r,
	output logic [`ALPHA_AMP_W-1:0]               alpha2_i
);
	import alpha_pkg::*;

	store_op_t                    store_op;
	logic                         list_load;
	logic [`ALPHA_MAX_VECTOR-1:0] p_lead_x;
	logic [`ALPHA_WORD_W-1:0]     alpha_word;

	alpha_ctrl u_ctrl (
		.clk                 (clk),
		.rst                 (rst),
		.cfg_we              (cfg_we),
		.cfg_cofactor_pos    (cfg_cofactor_pos),
		.valid_p             (valid_p),
		.valid_anticommute   (valid_anticommute),
		.flag_anticommute    (flag_anticommute),
		.done_amplitude      (done_amplitude),
		.store_op            (store_op),
		.list_load           (list_load),
		.determine_amplitude (determine_amplitude),
		.idle                (idle)
	);

	pauli_row_store u_store (
		.clk               (clk),
		.rst               (rst),
		.store_op          (store_op),
		.p_rows            (p_rows),
		.anticommute_row   (anticommute_row),
		.anticommute_phase (anticommute_phase),
		.q_rows            (q_rows),
		.q_phase           (q_phase),
		.p_lead_x          (p_lead_x)
	);

	alpha_order u_order (
		.clk               (clk),
		.rst               (rst),
		.list_load         (list_load),
		.p_lead_x          (p_lead_x),
		.anticommute_phase (anticommute_phase),
		.amp_rotate        (amp_rotate),
		.amp_r             (amp_r),
		.amp_i             (amp_i),
		.alpha_word        (alpha_word)
	);

	alpha_ram u_ram (
		.clk          (clk),
		.amp_write    (amp_write),
		.amp_address  (amp_address),
		.alpha_word   (alpha_word),
		.read_address (read_address),
		.alpha1_r     (alpha1_r),
		.alpha1_i     (alpha1_i),
		.alpha2_r     (alpha2_r),
		.alpha2_i     (alpha2_i)
	);

endmodule

`default_nettype wire

//--- tb_alpha_sva.sv
`default_nettype none

`include "alpha_settings.svh"

module alpha_ctrl_sva (
	input logic                                 clk,
	input logic                                 rst,
	input alpha_pkg::ctrl_state_t               state,
	input logic [$clog2(`ALPHA_NUM_QUBIT)-1:0]  step_cnt,
	input logic [$clog2(`ALPHA_NUM_QUBIT)-1:0]  cofactor_pos,
	input alpha_pkg::store_op_t                 store_op,
	input logic                                 determine_amplitude
);
	timeunit 1ns;
	timeprecision 1ps;
	import alpha_pkg::*;

	amp_pulse: assert property (@(posedge clk) disable iff (rst)
		determine_amplitude |=> !determine_amplitude)
		else $error("determine_amplitude stayed high for two cycles");

	// Alignment stops at the cofactor, and the count is held until restore
	cnt_range: assert property (@(posedge clk) disable iff (rst)
		(state inside {ST_ALIGN, ST_WAIT_FLAG, ST_AMPLITUDE}) |-> (step_cnt <= cofactor_pos))
		else $error("step counter beyond the cofactor position");

	// Idle only holds the rows or takes a new P
	idle_store: assert property (@(posedge clk) disable iff (rst)
		(state == ST_IDLE) |-> (store_op == OP_HOLD || store_op == OP_LOAD_P))
		else $error("row store rotating or loading Q while idle");

endmodule

bind alpha_ctrl alpha_ctrl_sva u_sva (
	.clk                 (clk),
	.rst                 (rst),
	.state               (state),
	.step_cnt            (step_cnt),
	.cofactor_pos        (cofactor_pos),
	.store_op            (store_op),
	.determine_amplitude (determine_amplitude)
);

`default_nettype wire

//--- tb_alpha.sv
`default_nettype none

`include "alpha_settings.svh"

module tb_alpha;
	timeunit 1ns;
	timeprecision 1ps;
	import alpha_pkg::*;

	localparam int NQ = `ALPHA_NUM_QUBIT;
	localparam int NV = `ALPHA_MAX_VECTOR;
	localparam int ITERATIONS = 40;
	localparam int AMP_OPS = 12;
	localparam int CYCLES_PER_ITER = 48; // Load, align, amplitude ops, reads, restore

	logic clk = 1'b0;
	logic rst;
	logic cfg_we;
	logic [$clog2(NQ)-1:0] cfg_cofactor_pos;
	logic valid_p;
	row_list_t p_rows;
	logic valid_anticommute;
	logic flag_anticommute;
	pauli_row_t anticommute_row;
	logic [NV-1:0] anticommute_phase;
	logic done_amplitude;
	logic amp_rotate;
	logic amp_write;
	logic [$clog2(NV)-1:0] amp_address;
	logic [`ALPHA_AMP_W-1:0] amp_r;
	logic [`ALPHA_AMP_W-1:0] amp_i;
	logic [$clog2(NV)-1:0] read_address;
	logic determine_amplitude;
	logic idle;
	row_list_t q_rows;
	logic [NV-1:0] q_phase;
	logic [`ALPHA_AMP_W-1:0] alpha1_r;
	logic [`ALPHA_AMP_W-1:0] alpha1_i;
	logic [`ALPHA_AMP_W-1:0] alpha2_r;
	logic [`ALPHA_AMP_W-1:0] alpha2_i;

	int unsigned seed = 7384;
	row_list_t exp_q; // Model of q_rows
	logic [NV-1:0] exp_qphase;
	logic [NV-1:0] exp_list; // Model of the P/Q list
	logic [`ALPHA_WORD_W-1:0] exp_mem [NV];
	logic [NV-1:0] written; // Addresses holding a known word

	alpha_basis_top uut (.*);

	always #20 clk = ~clk;

	function automatic logic [15:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[31:16]; // Upper bits have the longer period
	endfunction

	function automatic pauli_row_t rotate_row(input pauli_row_t row, input int n);
		pauli_row_t r;
		for (int j = 0; j < NQ; j++)
			r[j] = row[(j + n) % NQ];
		return r;
	endfunction

	// Returns {phase, row} of a times b
	function automatic logic [2*NQ:0] multiply_row(input pauli_row_t a, input pauli_row_t b,
			input logic ph);
		pauli_row_t r;
		int k;
		k = ph ? 2 : 0;
		for (int j = 0; j < NQ; j++)
		begin
			r[j] = pauli_t'(a[j] ^ b[j]);
			if (a[j] != PAULI_I && b[j] != PAULI_I && a[j] != b[j])
			begin
				if ((a[j] == PAULI_X && b[j] == PAULI_Y) || (a[j] == PAULI_Y && b[j] == PAULI_Z)
						|| (a[j] == PAULI_Z && b[j] == PAULI_X))
					k = k + 1; // Cyclic order X, Y, Z
				else
					k = k + 3;
			end
		end
		return {k[1], r};
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "value check failed");
	endtask

	task automatic report_failure(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "protocol check failed");
	endtask

	initial
	begin
		#((ITERATIONS * CYCLES_PER_ITER + 10) * 40 * 2);
		$display("timeout: the run took longer than its cycle budget");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		int pos;
		logic flag;
		logic [15:0] r;
		pauli_row_t arow;
		pauli_row_t aligned;
		logic [NV-1:0] aphase;
		logic [NV-1:0] rot_list;
		row_list_t prow;
		logic [2*NQ:0] prod;
		rst = 1'b1;
		cfg_we = 1'b0;
		cfg_cofactor_pos = '0;
		valid_p = 1'b0;
		p_rows = row_list_t'(0);
		valid_anticommute = 1'b0;
		flag_anticommute = 1'b0;
		anticommute_row = pauli_row_t'(0);
		anticommute_phase = '0;
		done_amplitude = 1'b0;
		amp_rotate = 1'b0;
		amp_write = 1'b0;
		amp_address = '0;
		amp_r = '0;
		amp_i = '0;
		read_address = '0;
		exp_q = row_list_t'(0);
		exp_qphase = '0;
		written = '0;
		repeat (3) @(posedge clk);
		#2 rst = 1'b0;
		assert (idle === 1'b1 && determine_amplitude === 1'b0)
			else report_mismatch("controller not idle after reset");
		for (int it = 0; it < ITERATIONS; it++)
		begin
			pos = int'(next_rand() % NQ);
			r = next_rand();
			flag = (r[1:0] != 2'b00); // Mostly randomized outcomes
			arow = pauli_row_t'(r[15:8]);
			aphase = next_rand();
			for (int i = 0; i < NV; i++)
			begin
				r = next_rand();
				prow[i] = pauli_row_t'(r[7:0]);
			end
			cfg_we = 1'b1; // Cofactor write and P load on the same idle edge
			cfg_cofactor_pos = 2'(pos);
			valid_p = 1'b1;
			p_rows = prow;
			tick();
			cfg_we = 1'b0;
			valid_p = 1'b0;
			repeat (pos + 1) tick();
			valid_anticommute = 1'b1;
			flag_anticommute = flag;
			anticommute_row = arow;
			anticommute_phase = aphase;
			tick();
			valid_anticommute = 1'b0;
			if (!flag)
			begin
				assert (determine_amplitude === 1'b0 && idle === 1'b1)
					else report_mismatch("deterministic outcome did not return to idle");
				assert (q_rows === exp_q && q_phase === exp_qphase)
					else report_mismatch("q rows changed on a deterministic outcome");
				tick();
				assert (determine_amplitude === 1'b0)
					else report_mismatch("amplitude request on a deterministic outcome");
			end
			else
			begin
				for (int i = 0; i < NV; i++)
				begin
					aligned = rotate_row(prow[i], pos);
					prod = multiply_row(aligned, arow, aphase[i]);
					exp_q[i] = pauli_row_t'(prod[2*NQ-1:0]);
					exp_qphase[i] = prod[2*NQ];
					exp_list[i] = (aligned[0] == PAULI_X || aligned[0] == PAULI_Y) ^ aphase[i];
				end
				assert (determine_amplitude === 1'b1)
					else report_mismatch("determine_amplitude not raised after the flag");
				assert (q_rows === exp_q && q_phase === exp_qphase)
					else report_mismatch("product rows or phases differ from the model");
				for (int k = 0; k < AMP_OPS; k++)
				begin
					r = next_rand();
					amp_rotate = r[0];
					amp_write = r[1];
					amp_address = r[7:4];
					amp_r = r[9:8];
					amp_i = r[11:10];
					if (r[1])
					begin
						exp_mem[r[7:4]] = exp_list[0] ? {r[9:8], r[11:10], 2'd1, 2'd0}
							: {2'd1, 2'd0, r[9:8], r[11:10]};
						written[r[7:4]] = 1'b1;
					end
					if (r[0])
					begin
						for (int i = 0; i < NV; i++)
							rot_list[i] = exp_list[(i + 1) % NV];
						exp_list = rot_list;
					end
					tick();
					assert (determine_amplitude === 1'b0)
						else report_mismatch("determine_amplitude held past its one cycle");
				end
				amp_rotate = 1'b0;
				amp_write = 1'b0;
				for (int a = 0; a < NV; a++)
				begin
					if (written[a])
					begin
						read_address = 4'(a);
						tick();
						assert ({alpha1_r, alpha1_i, alpha2_r, alpha2_i} === exp_mem[a])
							else report_mismatch($sformatf("alpha word at address %0d", a));
					end
				end
				done_amplitude = 1'b1;
				tick();
				done_amplitude = 1'b0;
				for (int w = 0; w < 2 * NQ && !idle; w++) // Restore length depends on pos
					tick();
				assert (idle === 1'b1) else report_failure("restore never returned to idle");
				for (int i = 0; i < NV; i++)
					exp_q[i] = rotate_row(exp_q[i], (NQ - pos) % NQ);
				assert (q_rows === exp_q && q_phase === exp_qphase)
					else report_mismatch("restored rows not in the original qubit order");
			end
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
alpha_pkg.sv
pauli_row_mult.sv
pauli_row_store.sv
alpha_order.sv
alpha_ram.sv
alpha_ctrl.sv
alpha_basis_top.sv
tb_alpha_sva.sv
tb_alpha.sv

//--- Makefile
SOURCES = alpha_settings.svh alpha_pkg.sv pauli_row_mult.sv pauli_row_store.sv alpha_order.sv \
	alpha_ram.sv alpha_ctrl.sv alpha_basis_top.sv tb_alpha_sva.sv tb_alpha.sv

obj_dir/Vtb_alpha: sources.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_alpha -f sources.f

run: obj_dir/Vtb_alpha
	./obj_dir/Vtb_alpha > sim.log 2>&1 || true
	@cat sim.log
	@grep -q '^STATUS: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
